/* source/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// dram side
`define LSU_DRAM_AW     31
`define LSU_AXI_DW      64

// on-chip buffers, one row is two read beats
`define LSU_ROW_W       128
`define LSU_ROW_BYTES   16
`define LSU_RAM_DEPTH   256

// byte address inside a buffer
`define LSU_SRAM_AW     12

// axi transaction id
`define LSU_ID_W        8

`endif

/* source/lsu_pkg.sv */
`default_nettype none
`include "lsu_params.svh"

package lsu_pkg;

    // instruction kinds the lsu still handles
    typedef enum logic [1:0] {
        ld_iram = 2'd0,
        ld_wram = 2'd1,
        conv    = 2'd2
    } lsu_op_e;

    // load payload, len is beats minus one
    typedef struct packed {
        logic [`LSU_DRAM_AW-1:0] dram_addr;
        logic [7:0]              len;
        logic [`LSU_SRAM_AW-1:0] ld_addr;
    } load_pld_t;

    // one buffer's window for a matrix read
    typedef struct packed {
        logic [`LSU_SRAM_AW-1:0] start_addr;
        logic                    col_dir;
        logic                    row_dir;
        logic [3:0]              col_len;
        logic [3:0]              row_len;
    } mm_side_t;

    typedef struct packed {
        mm_side_t   iram;
        mm_side_t   wram;
        logic [6:0] reserved;
    } mm_pld_t;

    // same instruction word, read by opcode
    typedef union packed {
        load_pld_t ld;
        mm_pld_t   mm;
    } lsu_pld_u;

    typedef logic [`LSU_ROW_W-1:0]     sram_row_t;
    typedef logic [`LSU_ROW_BYTES-1:0] row_vld_t;

endpackage

`default_nettype wire

/* source/lsu_inst_ctrl.sv */
`default_nettype none
`include "lsu_params.svh"

module lsu_inst_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inst_vld,
    input  lsu_pkg::lsu_op_e     inst_op,
    input  lsu_pkg::lsu_pld_u    inst_pld,
    input  logic                 ld_done,
    input  logic [1:0]           mm_done,
    output logic                 inst_rdy,
    output logic                 ld_start,
    output logic                 ld_bank_iram,
    output lsu_pkg::load_pld_t   ld_pld,
    output logic [`LSU_ID_W-1:0] ld_id,
    output logic                 mm_start,
    output lsu_pkg::mm_pld_t     mm_pld,
    output logic                 mxu_clr
);
    import lsu_pkg::*;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_load = 2'd1;
    localparam logic [1:0] st_conv = 2'd2;

    logic [1:0]           state_q;
    logic [1:0]           mm_pend_q;
    logic [1:0]           mm_left;
    logic [`LSU_ID_W-1:0] id_q;
    logic                 accept;
    logic                 bank_q;
    lsu_pld_u             pld_q;

    assign inst_rdy = (state_q == st_idle);
    assign accept   = inst_vld & inst_rdy;

    // readers still running, iram in bit 1
    assign mm_left = mm_pend_q & ~mm_done;

    ////////////////////////////////////////////////////////////
    // idle / busy
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= st_idle;
            mm_pend_q <= 2'b00;
            id_q      <= '0;
            ld_start  <= 1'b0;
            mm_start  <= 1'b0;
        end else begin
            ld_start <= 1'b0;
            mm_start <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        case (inst_op)
                            ld_iram, ld_wram: begin
                                state_q  <= st_load;
                                ld_start <= 1'b1;
                            end
                            conv: begin
                                state_q   <= st_conv;
                                mm_start  <= 1'b1;
                                mm_pend_q <= 2'b11;
                            end
                            // unknown opcode is dropped
                            default: state_q <= st_idle;
                        endcase
                    end
                end
                st_load: begin
                    if (ld_done) begin
                        state_q <= st_idle;
                        id_q    <= id_q + 1'b1;
                    end
                end
                st_conv: begin
                    mm_pend_q <= mm_left;
                    if (mm_left == 2'b00) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // payload held for the whole instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            pld_q  <= inst_pld;
            bank_q <= (inst_op == ld_iram);
        end
    end

    assign ld_pld       = pld_q.ld;
    assign mm_pld       = pld_q.mm;
    assign ld_bank_iram = bank_q;
    assign ld_id        = id_q;

    // clear goes out with the matrix start
    assign mxu_clr = mm_start;

endmodule

`default_nettype wire

/* source/load_buffer.sv */
`default_nettype none
`include "lsu_params.svh"

module load_buffer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start,
    input  logic                                bank_iram,
    input  lsu_pkg::load_pld_t                  pld,
    input  logic [`LSU_ID_W-1:0]                id,
    input  logic                                arrdy,
    input  logic                                rvld,
    input  logic [`LSU_AXI_DW-1:0]              rdata,
    input  logic                                rlast,
    output logic                                arvld,
    output logic [`LSU_ID_W-1:0]                arid,
    output logic [`LSU_DRAM_AW-1:0]             araddr,
    output logic [7:0]                          arlen,
    output logic                                rrdy,
    output logic                                wr_iram,
    output logic                                wr_wram,
    output logic [$clog2(`LSU_RAM_DEPTH)-1:0]   wr_row,
    output lsu_pkg::sram_row_t                  wr_data,
    output logic                                done
);
    import lsu_pkg::*;

    localparam int row_aw = $clog2(`LSU_RAM_DEPTH);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_addr = 2'd1;
    localparam logic [1:0] st_data = 2'd2;

    logic [1:0]             state_q;
    logic                   odd_q;
    logic [`LSU_AXI_DW-1:0] lo_q;
    logic [row_aw-1:0]      row_q;
    logic                   beat;
    logic                   wr_en;

    ////////////////////////////////////////////////////////////
    // address phase
    // the start cycle already presents the request
    assign arvld  = start | (state_q == st_addr);
    assign arid   = id;
    assign araddr = pld.dram_addr;
    assign arlen  = pld.len;

    ////////////////////////////////////////////////////////////
    // data phase
    assign rrdy = (state_q == st_data);
    assign beat = rvld & rrdy;
    assign done = beat & rlast;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_idle;
            odd_q   <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (start) begin
                        state_q <= arrdy ? st_data : st_addr;
                        odd_q   <= 1'b0;
                    end
                end
                st_addr: begin
                    if (arrdy) begin
                        state_q <= st_data;
                    end
                end
                st_data: begin
                    if (beat) begin
                        odd_q <= rlast ? 1'b0 : ~odd_q;
                        if (rlast) begin
                            state_q <= st_idle;
                        end
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // a row goes out on every odd beat, or on a lone last beat
    assign wr_en   = beat & (odd_q | rlast);
    assign wr_iram = wr_en & bank_iram;
    assign wr_wram = wr_en & ~bank_iram;
    assign wr_row  = row_q;
    assign wr_data = odd_q ? {rdata, lo_q} : {{`LSU_AXI_DW{1'b0}}, rdata};

    // even beat waits here for its partner
    always_ff @(posedge clk) begin
        if (beat && !odd_q) begin
            lo_q <= rdata;
        end
    end

    // row pointer from the upper bits of ld_addr
    always_ff @(posedge clk) begin
        if (start) begin
            row_q <= pld.ld_addr[`LSU_SRAM_AW-1 -: row_aw];
        end else if (wr_en) begin
            row_q <= row_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/ram_buffer.sv */
`default_nettype none
`include "lsu_params.svh"

module ram_buffer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start,
    input  lsu_pkg::mm_side_t                   side,
    input  lsu_pkg::sram_row_t                  rd_data,
    output logic                                rd_en,
    output logic [$clog2(`LSU_RAM_DEPTH)-1:0]   rd_row,
    output lsu_pkg::row_vld_t                   row_vld,
    output lsu_pkg::sram_row_t                  row_data,
    output logic                                done
);
    import lsu_pkg::*;

    localparam int row_aw = $clog2(`LSU_RAM_DEPTH);
    localparam int idx_w  = $clog2(`LSU_ROW_BYTES);

    logic                      active_q;
    logic [idx_w-1:0]          cnt_q;
    logic [row_aw-1:0]         row_q;
    logic                      last_rd;
    logic                      vld1_q;
    logic                      last1_q;
    logic [idx_w-1:0]          idx1_q;
    logic                      done_q;
    logic [`LSU_ROW_BYTES-1:0] mask_q;
    logic [`LSU_ROW_BYTES-1:0] mask_next;
    logic [idx_w-1:0]          start_byte;
    logic [idx_w-1:0]          end_byte;
    logic [idx_w-1:0]          lo_byte;
    logic [idx_w-1:0]          span;
    row_vld_t                  vld_q;
    sram_row_t                 data_q;

    ////////////////////////////////////////////////////////////
    // byte window wraps modulo the row width
    always_comb begin
        logic [idx_w-1:0] offs;
        start_byte = side.start_addr[idx_w-1:0];
        end_byte   = side.col_dir ? start_byte + side.col_len : start_byte - side.col_len;
        lo_byte    = side.col_dir ? start_byte : end_byte;
        // window covers col_len bytes above its low end in either direction
        span       = side.col_len;
        for (int b = 0; b < `LSU_ROW_BYTES; b++) begin
            offs         = idx_w'(b) - lo_byte;
            mask_next[b] = (offs <= span);
        end
    end

    ////////////////////////////////////////////////////////////
    // read walk at one row per cycle
    assign rd_en   = active_q;
    assign rd_row  = row_q;
    assign last_rd = active_q && (cnt_q == side.row_len);

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            row_q    <= '0;
            vld1_q   <= 1'b0;
            last1_q  <= 1'b0;
            vld_q    <= '0;
            done_q   <= 1'b0;
        end else begin
            if (start) begin
                active_q <= 1'b1;
                cnt_q    <= '0;
                row_q    <= side.start_addr[`LSU_SRAM_AW-1 -: row_aw];
            end else if (active_q) begin
                active_q <= ~last_rd;
                cnt_q    <= cnt_q + 1'b1;
                // row_dir 0 walks downward
                row_q    <= side.row_dir ? row_q + 1'b1 : row_q - 1'b1;
            end
            // one cycle of ram latency before the output stage
            vld1_q  <= active_q;
            last1_q <= last_rd;
            vld_q   <= vld1_q ? row_vld_t'(1) << idx1_q : '0;
            done_q  <= vld1_q & last1_q;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mask_q <= mask_next;
        end
        idx1_q <= cnt_q;
        for (int b = 0; b < `LSU_ROW_BYTES; b++) begin
            data_q[8*b +: 8] <= rd_data[8*b +: 8] & {8{mask_q[b]}};
        end
    end

    assign row_vld  = vld_q;
    assign row_data = data_q;
    assign done     = done_q;

endmodule

`default_nettype wire

/* source/sram_bank.sv */
`default_nettype none
`include "lsu_params.svh"

module sram_bank (
    input  logic                                clk,
    input  logic                                wr_en,
    input  logic [$clog2(`LSU_RAM_DEPTH)-1:0]   wr_row,
    input  lsu_pkg::sram_row_t                  wr_data,
    input  logic                                rd_en,
    input  logic [$clog2(`LSU_RAM_DEPTH)-1:0]   rd_row,
    output lsu_pkg::sram_row_t                  rd_data
);
    import lsu_pkg::*;

    sram_row_t mem [`LSU_RAM_DEPTH];

    // single port, write wins over a read in the same cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_row] <= wr_data;
        end else if (rd_en) begin
            rd_data <= mem[rd_row];
        end
    end

endmodule

`default_nettype wire

/* source/lsu.sv */
`default_nettype none
`include "lsu_params.svh"

module lsu (
    input  logic                    clk,
    input  logic                    reset,

    // decoder
    input  logic                    inst_vld,
    input  lsu_pkg::lsu_op_e        inst_op,
    input  lsu_pkg::lsu_pld_u       inst_pld,
    output logic                    inst_rdy,

    // axi read
    output logic                    arvld,
    output logic [`LSU_ID_W-1:0]    arid,
    output logic [`LSU_DRAM_AW-1:0] araddr,
    output logic [7:0]              arlen,
    input  logic                    arrdy,
    input  logic                    rvld,
    input  logic [`LSU_AXI_DW-1:0]  rdata,
    input  logic                    rlast,
    output logic                    rrdy,

    // matrix unit
    output logic                    mxu_clr,
    output lsu_pkg::row_vld_t       iram_vld,
    output lsu_pkg::sram_row_t      iram_pld,
    output lsu_pkg::row_vld_t       wram_vld,
    output lsu_pkg::sram_row_t      wram_pld
);
    import lsu_pkg::*;

    localparam int row_aw = $clog2(`LSU_RAM_DEPTH);

    logic                 ld_start;
    logic                 ld_bank_iram;
    load_pld_t            ld_pld;
    logic [`LSU_ID_W-1:0] ld_id;
    logic                 ld_done;
    logic                 mm_start;
    mm_pld_t              mm_pld;
    logic                 iram_done;
    logic                 wram_done;

    // load write port, shared by both banks
    logic                 wr_iram;
    logic                 wr_wram;
    logic [row_aw-1:0]    wr_row;
    sram_row_t            wr_data;

    logic                 iram_rd_en;
    logic [row_aw-1:0]    iram_rd_row;
    sram_row_t            iram_rd_data;
    logic                 wram_rd_en;
    logic [row_aw-1:0]    wram_rd_row;
    sram_row_t            wram_rd_data;

    ////////////////////////////////////////////////////////////
    // control
    lsu_inst_ctrl ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .inst_vld     (inst_vld),
        .inst_op      (inst_op),
        .inst_pld     (inst_pld),
        .ld_done      (ld_done),
        .mm_done      ({iram_done, wram_done}),
        .inst_rdy     (inst_rdy),
        .ld_start     (ld_start),
        .ld_bank_iram (ld_bank_iram),
        .ld_pld       (ld_pld),
        .ld_id        (ld_id),
        .mm_start     (mm_start),
        .mm_pld       (mm_pld),
        .mxu_clr      (mxu_clr)
    );

    ////////////////////////////////////////////////////////////
    // dram to buffer
    load_buffer load_i (
        .clk       (clk),
        .reset     (reset),
        .start     (ld_start),
        .bank_iram (ld_bank_iram),
        .pld       (ld_pld),
        .id        (ld_id),
        .arrdy     (arrdy),
        .rvld      (rvld),
        .rdata     (rdata),
        .rlast     (rlast),
        .arvld     (arvld),
        .arid      (arid),
        .araddr    (araddr),
        .arlen     (arlen),
        .rrdy      (rrdy),
        .wr_iram   (wr_iram),
        .wr_wram   (wr_wram),
        .wr_row    (wr_row),
        .wr_data   (wr_data),
        .done      (ld_done)
    );

    ////////////////////////////////////////////////////////////
    // input buffer
    sram_bank iram (
        .clk     (clk),
        .wr_en   (wr_iram),
        .wr_row  (wr_row),
        .wr_data (wr_data),
        .rd_en   (iram_rd_en),
        .rd_row  (iram_rd_row),
        .rd_data (iram_rd_data)
    );

    ram_buffer iram_reader (
        .clk      (clk),
        .reset    (reset),
        .start    (mm_start),
        .side     (mm_pld.iram),
        .rd_data  (iram_rd_data),
        .rd_en    (iram_rd_en),
        .rd_row   (iram_rd_row),
        .row_vld  (iram_vld),
        .row_data (iram_pld),
        .done     (iram_done)
    );

    ////////////////////////////////////////////////////////////
    // weight buffer
    sram_bank wram (
        .clk     (clk),
        .wr_en   (wr_wram),
        .wr_row  (wr_row),
        .wr_data (wr_data),
        .rd_en   (wram_rd_en),
        .rd_row  (wram_rd_row),
        .rd_data (wram_rd_data)
    );

    ram_buffer wram_reader (
        .clk      (clk),
        .reset    (reset),
        .start    (mm_start),
        .side     (mm_pld.wram),
        .rd_data  (wram_rd_data),
        .rd_en    (wram_rd_en),
        .rd_row   (wram_rd_row),
        .row_vld  (wram_vld),
        .row_data (wram_pld),
        .done     (wram_done)
    );

endmodule

`default_nettype wire

/* bench/lsu_properties.sv */
`default_nettype none
`include "lsu_params.svh"

module lsu_properties (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    arvld,
    input  logic [`LSU_ID_W-1:0]    arid,
    input  logic [`LSU_DRAM_AW-1:0] araddr,
    input  logic [7:0]              arlen,
    input  logic                    arrdy,
    input  logic                    rrdy,
    input  logic                    mxu_clr,
    input  lsu_pkg::row_vld_t       iram_vld,
    input  lsu_pkg::row_vld_t       wram_vld
);
    import lsu_pkg::*;

    ////////////////////////////////////////////////////////////
    // axi read address channel
    ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvld && !arrdy |=> arvld && $stable(arid) && $stable(araddr) && $stable(arlen))
        else $error("arvld or an address field changed before arrdy");

    // data phase only starts once the address is gone
    r_after_ar: assert property (@(posedge clk) disable iff (reset)
        !(rrdy && arvld))
        else $error("rrdy high while arvld is still high");

    ////////////////////////////////////////////////////////////
    // matrix unit side
    iram_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(iram_vld))
        else $error("iram_vld has more than one bit set");

    wram_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(wram_vld))
        else $error("wram_vld has more than one bit set");

    clr_pulse: assert property (@(posedge clk) disable iff (reset)
        mxu_clr |=> !mxu_clr)
        else $error("mxu_clr held for more than one cycle");

endmodule

bind lsu lsu_properties props_i (
    .clk      (clk),
    .reset    (reset),
    .arvld    (arvld),
    .arid     (arid),
    .araddr   (araddr),
    .arlen    (arlen),
    .arrdy    (arrdy),
    .rrdy     (rrdy),
    .mxu_clr  (mxu_clr),
    .iram_vld (iram_vld),
    .wram_vld (wram_vld)
);

`default_nettype wire

/* bench/lsu_tb.sv */
`default_nettype none
`include "lsu_params.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int row_aw = $clog2(`LSU_RAM_DEPTH);
    localparam int byte_w = $clog2(`LSU_ROW_BYTES);
    // five tests of well under 100 cycles each, wide margin for stalls
    localparam int max_cycles = 3000;

    logic                    clk;
    logic                    reset;
    logic                    inst_vld;
    lsu_op_e                 inst_op;
    lsu_pld_u                inst_pld;
    logic                    inst_rdy;
    logic                    arvld;
    logic [`LSU_ID_W-1:0]    arid;
    logic [`LSU_DRAM_AW-1:0] araddr;
    logic [7:0]              arlen;
    logic                    arrdy;
    logic                    rvld;
    logic [`LSU_AXI_DW-1:0]  rdata;
    logic                    rlast;
    logic                    rrdy;
    logic                    mxu_clr;
    row_vld_t                iram_vld;
    sram_row_t               iram_pld;
    row_vld_t                wram_vld;
    sram_row_t               wram_pld;

    // what each buffer should hold after the loads
    sram_row_t               ref_iram [`LSU_RAM_DEPTH];
    sram_row_t               ref_wram [`LSU_RAM_DEPTH];
    logic [`LSU_ID_W-1:0]    next_id;
    int                      row_errs;
    int                      ar_errs;
    int                      bit_errs;
    int                      cycle_cnt = 0;

    lsu dut_i (
        .clk      (clk),
        .reset    (reset),
        .inst_vld (inst_vld),
        .inst_op  (inst_op),
        .inst_pld (inst_pld),
        .inst_rdy (inst_rdy),
        .arvld    (arvld),
        .arid     (arid),
        .araddr   (araddr),
        .arlen    (arlen),
        .arrdy    (arrdy),
        .rvld     (rvld),
        .rdata    (rdata),
        .rlast    (rlast),
        .rrdy     (rrdy),
        .mxu_clr  (mxu_clr),
        .iram_vld (iram_vld),
        .iram_pld (iram_pld),
        .wram_vld (wram_vld),
        .wram_pld (wram_pld)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            bit_errs++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_ar(input logic [`LSU_ID_W-1:0] got_id,
                            input logic [`LSU_DRAM_AW-1:0] got_addr,
                            input logic [7:0] got_len,
                            input logic [`LSU_ID_W-1:0] exp_id,
                            input logic [`LSU_DRAM_AW-1:0] exp_addr,
                            input logic [7:0] exp_len);
        if (got_id !== exp_id || got_addr !== exp_addr || got_len !== exp_len) begin
            ar_errs++;
            $display("[FAIL] %0t: ar id/addr/len %h/%h/%h, expected %h/%h/%h", $time,
                     got_id, got_addr, got_len, exp_id, exp_addr, exp_len);
        end
    endtask

    task automatic check_row(input string side, input row_vld_t got_vld,
                             input sram_row_t got_data, input row_vld_t exp_vld,
                             input sram_row_t exp_data);
        if (got_vld !== exp_vld || got_data !== exp_data) begin
            row_errs++;
            $display("[FAIL] %0t: %s row vld %h data %h, expected vld %h data %h", $time,
                     side, got_vld, got_data, exp_vld, exp_data);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // helpers
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic issue(input lsu_op_e op, input lsu_pld_u pld);
        inst_vld = 1'b1;
        inst_op  = op;
        inst_pld = pld;
        @(negedge clk);
        check_bit("inst_rdy before accept", inst_rdy, 1'b1);
        next_cycle();
        inst_vld = 1'b0;
    endtask

    function automatic void write_ref(input logic to_iram, input logic [row_aw-1:0] row,
                                      input sram_row_t data);
        if (to_iram) begin
            ref_iram[row] = data;
        end else begin
            ref_wram[row] = data;
        end
    endfunction

    // window row k of one buffer, bytes outside the column range cleared
    function automatic sram_row_t expect_row(input logic from_iram, input mm_side_t side,
                                             input int k);
        logic [row_aw-1:0] row;
        logic [byte_w-1:0] b;
        sram_row_t         src;
        sram_row_t         res;
        row = side.start_addr[`LSU_SRAM_AW-1 -: row_aw];
        if (side.row_dir) begin
            row = row + row_aw'(k);
        end else begin
            row = row - row_aw'(k);
        end
        src = from_iram ? ref_iram[row] : ref_wram[row];
        res = '0;
        for (int j = 0; j <= int'(side.col_len); j++) begin
            if (side.col_dir) begin
                b = side.start_addr[byte_w-1:0] + byte_w'(j);
            end else begin
                b = side.start_addr[byte_w-1:0] - byte_w'(j);
            end
            res[8*b +: 8] = src[8*b +: 8];
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // load through the axi slave model
    task automatic run_load(input logic to_iram, input logic [`LSU_DRAM_AW-1:0] dram_addr,
                            input int beats, input logic [`LSU_SRAM_AW-1:0] ld_addr,
                            input int ar_wait, input logic gaps);
        lsu_pld_u               pld;
        logic [`LSU_AXI_DW-1:0] beat_data;
        logic [`LSU_AXI_DW-1:0] lo_half;
        logic [row_aw-1:0]      row;
        logic                   taken;
        int                     gap;
        pld              = '0;
        pld.ld.dram_addr = dram_addr;
        pld.ld.len       = 8'(beats - 1);
        pld.ld.ld_addr   = ld_addr;
        row              = ld_addr[`LSU_SRAM_AW-1 -: row_aw];
        lo_half          = '0;
        if (to_iram) begin
            issue(ld_iram, pld);
        end else begin
            issue(ld_wram, pld);
        end
        @(negedge clk);
        check_bit("arvld after accept", arvld, 1'b1);
        check_bit("inst_rdy during load", inst_rdy, 1'b0);
        check_ar(arid, araddr, arlen, next_id, dram_addr, 8'(beats - 1));
        // slave holds off the address
        repeat (ar_wait) begin
            next_cycle();
            @(negedge clk);
            check_bit("arvld while arrdy low", arvld, 1'b1);
            check_bit("rrdy in address phase", rrdy, 1'b0);
            check_ar(arid, araddr, arlen, next_id, dram_addr, 8'(beats - 1));
        end
        next_cycle();
        arrdy = 1'b1;
        @(negedge clk);
        check_bit("arvld at handshake", arvld, 1'b1);
        check_ar(arid, araddr, arlen, next_id, dram_addr, 8'(beats - 1));
        next_cycle();
        arrdy = 1'b0;

        for (int i = 0; i < beats; i++) begin
            gap = gaps ? int'($urandom % 3) : 0;
            repeat (gap) begin
                @(negedge clk);
                check_bit("rrdy during rvld gap", rrdy, 1'b1);
                next_cycle();
            end
            beat_data = {$urandom, $urandom};
            rvld      = 1'b1;
            rdata     = beat_data;
            rlast     = (i == beats - 1);
            // beat held until the lsu takes it
            do begin
                @(negedge clk);
                check_bit("arvld in data phase", arvld, 1'b0);
                check_bit("inst_rdy during load", inst_rdy, 1'b0);
                taken = rrdy;
                next_cycle();
            end while (!taken);
            rvld  = 1'b0;
            rlast = 1'b0;
            if (i % 2 == 0) begin
                lo_half = beat_data;
                if (i == beats - 1) begin
                    write_ref(to_iram, row, {{`LSU_AXI_DW{1'b0}}, beat_data});
                end
            end else begin
                write_ref(to_iram, row, {beat_data, lo_half});
                row = row + 1'b1;
            end
        end
        next_id = next_id + 1'b1;
        @(negedge clk);
        check_bit("inst_rdy after rlast", inst_rdy, 1'b1);
        check_bit("rrdy after rlast", rrdy, 1'b0);
        next_cycle();
    endtask

    ////////////////////////////////////////////////////////////
    // convolution window read
    task automatic run_conv(input mm_side_t iside, input mm_side_t wside);
        lsu_pld_u pld;
        int       i_cnt;
        int       w_cnt;
        int       clr_cnt;
        pld         = '0;
        pld.mm.iram = iside;
        pld.mm.wram = wside;
        i_cnt       = 0;
        w_cnt       = 0;
        clr_cnt     = 1;
        issue(conv, pld);
        @(negedge clk);
        check_bit("mxu_clr after accept", mxu_clr, 1'b1);
        check_bit("inst_rdy during conv", inst_rdy, 1'b0);
        next_cycle();
        @(negedge clk);
        while (!inst_rdy) begin
            if (mxu_clr) begin
                clr_cnt++;
            end
            if (iram_vld !== '0) begin
                check_row("iram", iram_vld, iram_pld, row_vld_t'(1) << i_cnt,
                          expect_row(1'b1, iside, i_cnt));
                i_cnt++;
            end
            if (wram_vld !== '0) begin
                check_row("wram", wram_vld, wram_pld, row_vld_t'(1) << w_cnt,
                          expect_row(1'b0, wside, w_cnt));
                w_cnt++;
            end
            next_cycle();
            @(negedge clk);
        end
        if (clr_cnt != 1 || i_cnt != int'(iside.row_len) + 1
                || w_cnt != int'(wside.row_len) + 1) begin
            row_errs++;
            $display("[FAIL] %0t: %0d clear pulses, %0d iram rows, %0d wram rows", $time,
                     clr_cnt, i_cnt, w_cnt);
        end
        check_bit("iram_vld idle after conv", iram_vld === '0, 1'b1);
        check_bit("wram_vld idle after conv", wram_vld === '0, 1'b1);
        next_cycle();
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    task automatic test_reset_state();
        @(negedge clk);
        check_bit("inst_rdy after reset", inst_rdy, 1'b1);
        check_bit("arvld after reset", arvld, 1'b0);
        check_bit("rrdy after reset", rrdy, 1'b0);
        check_bit("mxu_clr after reset", mxu_clr, 1'b0);
        check_bit("iram_vld zero after reset", iram_vld === '0, 1'b1);
        check_bit("wram_vld zero after reset", wram_vld === '0, 1'b1);
        next_cycle();
    endtask

    task automatic test_iram_load();
        run_load(1'b1, 31'h1234_5670, 8, 12'h050, 0, 1'b0);
    endtask

    // odd beat count, late arrdy and gaps in rvld
    task automatic test_wram_load();
        run_load(1'b0, 31'h0abc_de08, 5, 12'h1a0, 3, 1'b1);
    endtask

    task automatic test_conv_up();
        run_conv('{start_addr: 12'h050, col_dir: 1'b1, row_dir: 1'b1,
                   col_len: 4'd15, row_len: 4'd3},
                 '{start_addr: 12'h1a3, col_dir: 1'b1, row_dir: 1'b1,
                   col_len: 4'd15, row_len: 4'd2});
    endtask

    // downward rows, wrapping byte window on the wram side
    task automatic test_conv_down();
        run_conv('{start_addr: 12'h08a, col_dir: 1'b0, row_dir: 1'b0,
                   col_len: 4'd5, row_len: 4'd3},
                 '{start_addr: 12'h1c2, col_dir: 1'b0, row_dir: 1'b0,
                   col_len: 4'd6, row_len: 4'd2});
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        inst_vld = 1'b0;
        inst_op  = ld_iram;
        inst_pld = '0;
        arrdy    = 1'b0;
        rvld     = 1'b0;
        rdata    = '0;
        rlast    = 1'b0;
        next_id  = '0;
        row_errs = 0;
        ar_errs  = 0;
        bit_errs = 0;
        void'($urandom(32'h3d05_fdea));
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        test_reset_state();
        test_iram_load();
        test_wram_load();
        test_conv_up();
        test_conv_down();

        $display("errors: %0d row, %0d address, %0d control", row_errs, ar_errs, bit_errs);
        if (row_errs + ar_errs + bit_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lsu.f */
+incdir+source
source/lsu_pkg.sv
source/lsu_inst_ctrl.sv
source/load_buffer.sv
source/ram_buffer.sv
source/sram_bank.sv
source/lsu.sv
bench/lsu_properties.sv
bench/lsu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the lsu testbench with verilator
cd "$(dirname "$0")" || exit 1
sim_out=""
verilator --binary --timing --assert -f lsu.f --top-module lsu_tb -Mdir obj_dir \
    && sim_out="$(./obj_dir/Vlsu_tb)"
echo "$sim_out"
echo "$sim_out" | grep -q "Test completed successfully" \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }
